// File: src/exuPkg.sv
//##########################################################################
// Shared types for the RV64 execute stage: widths, opcode enums, CSR
// numbers and the control bundle handed over by the decoder.
// Modules import it inside their bodies and use scoped names in headers.
//##########################################################################
package exuPkg;

    localparam int xlen     = 64;
    localparam int regAddrW = 5;
    localparam int csrAddrW = 12;

    typedef enum logic [4:0] {
        aluAdd   = 5'd0,
        aluSub   = 5'd1,
        aluSll   = 5'd2,
        aluSlt   = 5'd3,
        aluSltu  = 5'd4,
        aluXor   = 5'd5,
        aluSrl   = 5'd6,
        aluSra   = 5'd7,
        aluOr    = 5'd8,
        aluAnd   = 5'd9,
        aluAddw  = 5'd10,
        aluSubw  = 5'd11,
        aluSllw  = 5'd12,
        aluSrlw  = 5'd13,
        aluSraw  = 5'd14,
        aluPassB = 5'd15
    } aluOpE;

    // code 3 is unused
    typedef enum logic [2:0] {
        brNone = 3'd0,
        brJal  = 3'd1,
        brJalr = 3'd2,
        brBeq  = 3'd4,
        brBne  = 3'd5,
        brBlt  = 3'd6,
        brBge  = 3'd7
    } branchE;

    // same codes as funct3, stores reuse the size part
    typedef enum logic [2:0] {
        memLb  = 3'd0,
        memLh  = 3'd1,
        memLw  = 3'd2,
        memLd  = 3'd3,
        memLbu = 3'd4,
        memLhu = 3'd5,
        memLwu = 3'd6
    } memOpE;

    typedef enum logic [1:0] {
        csrWrite = 2'd0,
        csrSet   = 2'd1,
        csrClear = 2'd2
    } csrOpE;

    typedef enum logic [1:0] {
        fromReg   = 2'd0,
        fromImm   = 2'd1,
        constFour = 2'd2
    } srcBE;

    localparam logic [csrAddrW-1:0] csrMstatus = 12'h300;
    localparam logic [csrAddrW-1:0] csrMtvec   = 12'h305;
    localparam logic [csrAddrW-1:0] csrMepc    = 12'h341;
    localparam logic [csrAddrW-1:0] csrMcause  = 12'h342;

    typedef struct packed {
        logic   regWen;
        // 1 selects rs1 data, 0 selects pc
        logic   aluSrcA;
        srcBE   srcB;
        aluOpE  aluOp;
        branchE branch;
        memOpE  memOp;
        logic   memWen;
        logic   memToReg;
        logic   csrWen;
        csrOpE  csrOp;
        logic   csrToReg;
        logic   epc;
        logic   mret;
    } exuCtrl;

endpackage

// File: src/regFile.sv
//##########################################################################
// Integer register file, 32 x 64, two async reads and one sync write.
// x0 always reads zero; reset clears every entry.
//##########################################################################
`timescale 1ns/100ps

module regFile (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [exuPkg::regAddrW-1:0]   raAddr,
    input  logic [exuPkg::regAddrW-1:0]   rbAddr,
    input  logic [exuPkg::regAddrW-1:0]   wAddr,
    input  logic [exuPkg::xlen-1:0]       wData,
    input  logic                          wEn,
    output logic [exuPkg::xlen-1:0]       raData,
    output logic [exuPkg::xlen-1:0]       rbData
);
    import exuPkg::*;

    logic [xlen-1:0] regs [2**regAddrW];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**regAddrW; i++) begin
                regs[i] <= '0;
            end
        end else if (wEn && wAddr != '0) begin
            regs[wAddr] <= wData;
        end
    end

    assign raData = (raAddr == '0) ? '0 : regs[raAddr];
    assign rbData = (rbAddr == '0) ? '0 : regs[rbAddr];

endmodule

// File: src/alu.sv
//##########################################################################
// 64-bit integer ALU for the execute stage, with RV64 word variants.
// Purely combinational; zero flags an all-zero result for branches.
//##########################################################################
`timescale 1ns/100ps

module alu (
    input  logic [exuPkg::xlen-1:0] a,
    input  logic [exuPkg::xlen-1:0] b,
    input  exuPkg::aluOpE           op,
    output logic [exuPkg::xlen-1:0] result,
    output logic                    zero
);
    import exuPkg::*;

    logic [31:0] wordRes;

    // low 32-bit results for the *w ops
    always_comb begin
        case (op)
            aluAddw: wordRes = a[31:0] + b[31:0];
            aluSubw: wordRes = a[31:0] - b[31:0];
            aluSllw: wordRes = a[31:0] << b[4:0];
            aluSrlw: wordRes = a[31:0] >> b[4:0];
            aluSraw: wordRes = $signed(a[31:0]) >>> b[4:0];
            default: wordRes = '0;
        endcase
    end

    always_comb begin
        case (op)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluSll:   result = a << b[5:0];
            aluSlt:   result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            aluSltu:  result = {{(xlen-1){1'b0}}, a < b};
            aluXor:   result = a ^ b;
            aluSrl:   result = a >> b[5:0];
            aluSra:   result = $signed(a) >>> b[5:0];
            aluOr:    result = a | b;
            aluAnd:   result = a & b;
            aluAddw,
            aluSubw,
            aluSllw,
            aluSrlw,
            aluSraw:  result = {{(xlen-32){wordRes[31]}}, wordRes};
            // lui
            aluPassB: result = b;
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: src/csrUnit.sv
//##########################################################################
// Machine-mode CSR file with write/set/clear ops. Reads return the value
// before the edge; mepc is exported for mret. Unknown numbers read zero.
//##########################################################################
`timescale 1ns/100ps

module csrUnit (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          wEn,
    input  exuPkg::csrOpE                 op,
    input  logic [exuPkg::csrAddrW-1:0]   id,
    input  logic [exuPkg::xlen-1:0]       dataIn,
    output logic [exuPkg::xlen-1:0]       oldValue,
    output logic [exuPkg::xlen-1:0]       mepc
);
    import exuPkg::*;

    logic [xlen-1:0] mstatus;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mcause;
    logic [xlen-1:0] newValue;

    always_comb begin
        case (id)
            csrMstatus: oldValue = mstatus;
            csrMtvec:   oldValue = mtvec;
            csrMepc:    oldValue = mepc;
            csrMcause:  oldValue = mcause;
            default:    oldValue = '0;
        endcase
    end

    always_comb begin
        case (op)
            csrWrite: newValue = dataIn;
            csrSet:   newValue = oldValue | dataIn;
            csrClear: newValue = oldValue & ~dataIn;
            default:  newValue = oldValue;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (wEn) begin
            case (id)
                csrMstatus: mstatus <= newValue;
                csrMtvec:   mtvec   <= newValue;
                csrMepc:    mepc    <= newValue;
                csrMcause:  mcause  <= newValue;
                default: ;
            endcase
        end
    end

endmodule

// File: src/nextPc.sv
//##########################################################################
// Next-pc selection: branch decode picks base and increment, one adder
// sums them, mret overrides with mepc. Bit 0 is cleared by the caller.
//##########################################################################
`timescale 1ns/100ps

module nextPc (
    input  logic [exuPkg::xlen-1:0] pc,
    input  logic [exuPkg::xlen-1:0] imm,
    input  logic [exuPkg::xlen-1:0] rs1Data,
    input  logic [exuPkg::xlen-1:0] mepc,
    input  exuPkg::branchE          branch,
    input  logic                    zero,
    input  logic                    lsb,
    input  logic                    mret,
    output logic [exuPkg::xlen-1:0] target
);
    import exuPkg::*;

    logic            useRs1;
    logic            useImm;
    logic [xlen-1:0] base;
    logic [xlen-1:0] step;

    // lsb is the slt/sltu result bit
    always_comb begin
        useRs1 = 1'b0;
        useImm = 1'b0;
        case (branch)
            brJal:  useImm = 1'b1;
            brJalr: begin
                useRs1 = 1'b1;
                useImm = 1'b1;
            end
            brBeq:  useImm = zero;
            brBne:  useImm = ~zero;
            brBlt:  useImm = lsb;
            brBge:  useImm = zero | ~lsb;
            default: ;
        endcase
    end

    assign base   = useRs1 ? rs1Data : pc;
    assign step   = useImm ? imm : xlen'(4);
    assign target = mret ? mepc : base + step;

endmodule

// File: src/dataMem.sv
//##########################################################################
// Local data memory of doublewords with byte-lane stores and sized,
// sign- or zero-extending loads. Index wraps modulo memWords.
//##########################################################################
`timescale 1ns/100ps

module dataMem #(
    parameter int memWords = 256
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [exuPkg::xlen-1:0] addr,
    input  logic [exuPkg::xlen-1:0] storeData,
    input  exuPkg::memOpE           op,
    input  logic                    wEn,
    output logic [exuPkg::xlen-1:0] loadData
);
    import exuPkg::*;

    // memWords is expected to be a power of two
    localparam int idxW = $clog2(memWords);

    logic [xlen-1:0] mem [memWords];
    logic [idxW-1:0] idx;
    logic [xlen-1:0] rdWord;
    logic [xlen-1:0] shifted;
    logic [xlen-1:0] wrData;
    logic [7:0]      sizeMask;
    logic [7:0]      laneMask;

    assign idx     = addr[3 +: idxW];
    assign rdWord  = mem[idx];
    assign shifted = rdWord >> {addr[2:0], 3'b000};

    always_comb begin
        case (op)
            memLb:   loadData = {{(xlen-8){shifted[7]}}, shifted[7:0]};
            memLh:   loadData = {{(xlen-16){shifted[15]}}, shifted[15:0]};
            memLw:   loadData = {{(xlen-32){shifted[31]}}, shifted[31:0]};
            memLbu:  loadData = {{(xlen-8){1'b0}}, shifted[7:0]};
            memLhu:  loadData = {{(xlen-16){1'b0}}, shifted[15:0]};
            memLwu:  loadData = {{(xlen-32){1'b0}}, shifted[31:0]};
            default: loadData = rdWord;
        endcase
    end

    // lanes past byte 7 are dropped
    always_comb begin
        case (op)
            memLb, memLbu: sizeMask = 8'h01;
            memLh, memLhu: sizeMask = 8'h03;
            memLw, memLwu: sizeMask = 8'h0f;
            default:       sizeMask = 8'hff;
        endcase
    end

    assign laneMask = sizeMask << addr[2:0];
    assign wrData   = storeData << {addr[2:0], 3'b000};

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < memWords; i++) begin
                mem[i] <= '0;
            end
        end else if (wEn) begin
            for (int lane = 0; lane < 8; lane++) begin
                if (laneMask[lane]) begin
                    mem[idx][8*lane +: 8] <= wrData[8*lane +: 8];
                end
            end
        end
    end

endmodule

// File: src/execUnit.sv
//##########################################################################
// Single-cycle RV64 execute stage. Takes the decoded control bundle and
// operands, produces next pc and writeback data in the same cycle, and
// commits register, CSR and memory writes at the next rising edge.
//##########################################################################
`timescale 1ns/100ps

module execUnit #(
    parameter int memWords = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  exuPkg::exuCtrl                ctrl,
    input  logic [exuPkg::regAddrW-1:0]   rd,
    input  logic [exuPkg::regAddrW-1:0]   rs1,
    input  logic [exuPkg::regAddrW-1:0]   rs2,
    input  logic [exuPkg::xlen-1:0]       pc,
    input  logic [exuPkg::xlen-1:0]       imm,
    output logic [exuPkg::xlen-1:0]       dnpc,
    output logic [exuPkg::xlen-1:0]       wbData
);
    import exuPkg::*;

    logic [xlen-1:0] rs1Data;
    logic [xlen-1:0] rs2Data;
    logic [xlen-1:0] aluA;
    logic [xlen-1:0] aluB;
    logic [xlen-1:0] aluRes;
    logic [xlen-1:0] loadData;
    logic [xlen-1:0] csrIn;
    logic [xlen-1:0] csrOld;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] target;
    logic            aluZero;
    logic            regWe;

    assign regWe = ctrl.regWen & ~reset;

    assign aluA = ctrl.aluSrcA ? rs1Data : pc;

    always_comb begin
        case (ctrl.srcB)
            fromReg: aluB = rs2Data;
            fromImm: aluB = imm;
            default: aluB = xlen'(4);
        endcase
    end

    // csr old value wins over load data
    assign wbData = ctrl.csrToReg ? csrOld : (ctrl.memToReg ? loadData : aluRes);

    assign csrIn = ctrl.epc ? pc : rs1Data;

    regFile uRegFile (
        .clk    (clk),
        .reset  (reset),
        .raAddr (rs1),
        .rbAddr (rs2),
        .wAddr  (rd),
        .wData  (wbData),
        .wEn    (regWe),
        .raData (rs1Data),
        .rbData (rs2Data)
    );

    alu uAlu (
        .a      (aluA),
        .b      (aluB),
        .op     (ctrl.aluOp),
        .result (aluRes),
        .zero   (aluZero)
    );

    csrUnit uCsr (
        .clk      (clk),
        .reset    (reset),
        .wEn      (ctrl.csrWen),
        .op       (ctrl.csrOp),
        .id       (imm[csrAddrW-1:0]),
        .dataIn   (csrIn),
        .oldValue (csrOld),
        .mepc     (mepc)
    );

    dataMem #(
        .memWords (memWords)
    ) uDataMem (
        .clk       (clk),
        .reset     (reset),
        .addr      (aluRes),
        .storeData (rs2Data),
        .op        (ctrl.memOp),
        .wEn       (ctrl.memWen),
        .loadData  (loadData)
    );

    nextPc uNextPc (
        .pc      (pc),
        .imm     (imm),
        .rs1Data (rs1Data),
        .mepc    (mepc),
        .branch  (ctrl.branch),
        .zero    (aluZero),
        .lsb     (aluRes[0]),
        .mret    (ctrl.mret),
        .target  (target)
    );

    assign dnpc = {target[xlen-1:1], 1'b0};

endmodule

// File: tests/execUnit_checker.sv
//##########################################################################
// Concurrent assertions on the execute stage top level, bound into
// execUnit. Covers sequential next pc, jalr targets and reset writes.
//##########################################################################
`timescale 1ns/100ps

module execUnit_checker (
    input  logic                    clk,
    input  logic                    reset,
    input  exuPkg::exuCtrl          ctrl,
    input  logic [exuPkg::xlen-1:0] pc,
    input  logic [exuPkg::xlen-1:0] imm,
    input  logic [exuPkg::xlen-1:0] rs1Data,
    input  logic [exuPkg::xlen-1:0] dnpc
);
    import exuPkg::*;

    int failCount = 0;

    // jalr target is rs1+imm with bit 0 cleared
    jalrTarget: assert property (@(posedge clk)
        (ctrl.branch == brJalr && !ctrl.mret) |-> (dnpc == ((rs1Data + imm) & ~64'd1)))
        else begin
            failCount++;
            $error("jalr dnpc is not rs1+imm with bit 0 cleared");
        end

    // sequential flow
    seqPc: assert property (@(posedge clk)
        (ctrl.branch == brNone && !ctrl.mret) |-> (dnpc == pc + 64'd4))
        else begin
            failCount++;
            $error("dnpc is not pc+4 on a non-branch row");
        end

    // a write during reset would show on the next read of rs1
    noWriteInReset: assert property (@(posedge clk) reset |=> (rs1Data == '0))
        else begin
            failCount++;
            $error("register file kept a write made during reset");
        end

endmodule

bind execUnit execUnit_checker uChecker (
    .clk     (clk),
    .reset   (reset),
    .ctrl    (ctrl),
    .pc      (pc),
    .imm     (imm),
    .rs1Data (rs1Data),
    .dnpc    (dnpc)
);

// File: tests/execMonitor.sv
//##########################################################################
// Watches dnpc and wbData of the execute stage one ns before each rising
// edge and compares them with the expected values of the current row.
//##########################################################################
`timescale 1ns/100ps

module execMonitor #(
    parameter int halfPeriod = 10
) (
    input  logic                    clk,
    input  logic                    checkEn,
    input  int                      rowIdx,
    input  logic [exuPkg::xlen-1:0] dnpc,
    input  logic [exuPkg::xlen-1:0] wbData,
    input  logic [exuPkg::xlen-1:0] expDnpc,
    input  logic [exuPkg::xlen-1:0] expWb,
    output int                      errorCount,
    output int                      checkCount
);
    import exuPkg::*;

    int errs = 0;
    int checks = 0;

    assign errorCount = errs;
    assign checkCount = checks;

    // rows change on the falling edge, sample late in the low phase
    always @(negedge clk) begin
        #(halfPeriod - 1);
        if (checkEn) begin
            checks++;
            if (dnpc !== expDnpc) begin
                errs++;
                $display("ERROR at %0t: row %0d dnpc is %h, expected %h",
                         $time, rowIdx, dnpc, expDnpc);
            end
            if (wbData !== expWb) begin
                errs++;
                $display("ERROR at %0t: row %0d wbData is %h, expected %h",
                         $time, rowIdx, wbData, expWb);
            end
        end
    end

endmodule

// File: tests/execUnit_tb.sv
//##########################################################################
// Testbench for the execute stage: builds a table of rows, drives one
// row per falling edge and lets execMonitor compare the results.
//##########################################################################
`timescale 1ns/100ps

module execUnit_tb;
    import exuPkg::*;

    localparam int halfPeriod  = 10;
    localparam int resetCycles = 16;
    localparam logic [xlen-1:0] memBase = 64'h40;

    typedef struct packed {
        exuCtrl              ctrl;
        logic [regAddrW-1:0] rd;
        logic [regAddrW-1:0] rs1;
        logic [regAddrW-1:0] rs2;
        logic [xlen-1:0]     pc;
        logic [xlen-1:0]     imm;
        logic [xlen-1:0]     expDnpc;
        logic [xlen-1:0]     expWb;
    } rowT;

    logic                clk;
    logic                reset;
    exuCtrl              ctrl;
    logic [regAddrW-1:0] rd;
    logic [regAddrW-1:0] rs1;
    logic [regAddrW-1:0] rs2;
    logic [xlen-1:0]     pc;
    logic [xlen-1:0]     imm;
    logic [xlen-1:0]     dnpc;
    logic [xlen-1:0]     wbData;
    logic                checkEn;
    logic [xlen-1:0]     expDnpc;
    logic [xlen-1:0]     expWb;
    int                  rowIdx;
    int                  errorCount;
    int                  checkCount;
    bit                  tableReady = 1'b0;

    rowT             rows[$];
    logic [xlen-1:0] curPc = 64'h8000_0000;

    initial clk = 1'b0;
    always #halfPeriod clk = ~clk;

    execUnit #(
        .memWords (256)
    ) DUT (
        .clk    (clk),
        .reset  (reset),
        .ctrl   (ctrl),
        .rd     (rd),
        .rs1    (rs1),
        .rs2    (rs2),
        .pc     (pc),
        .imm    (imm),
        .dnpc   (dnpc),
        .wbData (wbData)
    );

    execMonitor #(
        .halfPeriod (halfPeriod)
    ) uMonitor (
        .clk        (clk),
        .checkEn    (checkEn),
        .rowIdx     (rowIdx),
        .dnpc       (dnpc),
        .wbData     (wbData),
        .expDnpc    (expDnpc),
        .expWb      (expWb),
        .errorCount (errorCount),
        .checkCount (checkCount)
    );

    // rs1 as operand A, everything else off
    function automatic exuCtrl baseCtrl();
        exuCtrl c;
        c = '0;
        c.aluSrcA = 1'b1;
        return c;
    endfunction

    task automatic addRow(input exuCtrl c, input logic [regAddrW-1:0] rdN,
                          input logic [regAddrW-1:0] rs1N, input logic [regAddrW-1:0] rs2N,
                          input logic [xlen-1:0] immV, input logic [xlen-1:0] expD,
                          input logic [xlen-1:0] expW);
        rowT r;
        r.ctrl = c;
        r.rd = rdN;
        r.rs1 = rs1N;
        r.rs2 = rs2N;
        r.pc = curPc;
        r.imm = immV;
        r.expDnpc = expD;
        r.expWb = expW;
        rows.push_back(r);
        curPc = curPc + 64'd4;
    endtask

    task automatic opImm(input aluOpE op, input logic [regAddrW-1:0] rdN,
                         input logic [regAddrW-1:0] rs1N, input logic [xlen-1:0] immV,
                         input logic [xlen-1:0] expW);
        exuCtrl c;
        c = baseCtrl();
        c.regWen = 1'b1;
        c.srcB = fromImm;
        c.aluOp = op;
        addRow(c, rdN, rs1N, 5'd0, immV, curPc + 64'd4, expW);
    endtask

    task automatic opReg(input aluOpE op, input logic [regAddrW-1:0] rdN,
                         input logic [regAddrW-1:0] rs1N, input logic [regAddrW-1:0] rs2N,
                         input logic [xlen-1:0] expW);
        exuCtrl c;
        c = baseCtrl();
        c.regWen = 1'b1;
        c.aluOp = op;
        addRow(c, rdN, rs1N, rs2N, 64'd0, curPc + 64'd4, expW);
    endtask

    // add rs, x0 into x0 shows the register on wbData
    task automatic readReg(input logic [regAddrW-1:0] rsN, input logic [xlen-1:0] expW);
        opReg(aluAdd, 5'd0, rsN, 5'd0, expW);
    endtask

    task automatic branchRow(input branchE br, input aluOpE op,
                             input logic [regAddrW-1:0] rs1N, input logic [regAddrW-1:0] rs2N,
                             input logic [xlen-1:0] immV, input bit taken,
                             input logic [xlen-1:0] expW);
        exuCtrl c;
        c = baseCtrl();
        c.aluOp = op;
        c.branch = br;
        addRow(c, 5'd0, rs1N, rs2N, immV, taken ? curPc + immV : curPc + 64'd4, expW);
    endtask

    // loads and stores address off x23
    task automatic memLoad(input memOpE op, input logic [regAddrW-1:0] rdN,
                           input logic [xlen-1:0] off, input logic [xlen-1:0] expW);
        exuCtrl c;
        c = baseCtrl();
        c.regWen = 1'b1;
        c.srcB = fromImm;
        c.memOp = op;
        c.memToReg = 1'b1;
        addRow(c, rdN, 5'd23, 5'd0, off, curPc + 64'd4, expW);
    endtask

    task automatic memStore(input memOpE op, input logic [regAddrW-1:0] rs2N,
                            input logic [xlen-1:0] off);
        exuCtrl c;
        c = baseCtrl();
        c.srcB = fromImm;
        c.memOp = op;
        c.memWen = 1'b1;
        addRow(c, 5'd0, 5'd23, rs2N, off, curPc + 64'd4, memBase + off);
    endtask

    task automatic csrRow(input csrOpE op, input logic [regAddrW-1:0] rdN,
                          input logic [regAddrW-1:0] rs1N, input logic [11:0] id,
                          input logic [xlen-1:0] expW);
        exuCtrl c;
        c = baseCtrl();
        c.regWen = 1'b1;
        c.csrWen = 1'b1;
        c.csrOp = op;
        c.csrToReg = 1'b1;
        addRow(c, rdN, rs1N, 5'd0, {52'd0, id}, curPc + 64'd4, expW);
    endtask

    task automatic buildTable();
        exuCtrl          c;
        logic [xlen-1:0] linkPc;
        logic [xlen-1:0] epcPc;
        // registers are clear after reset
        for (int i = 0; i < 32; i++) begin
            readReg(5'(i), 64'd0);
        end
        opImm(aluAdd, 5'd1, 5'd0, 64'd7, 64'd7);
        opImm(aluAdd, 5'd2, 5'd0, 64'hFFFF_FFFF_FFFF_FFFD, 64'hFFFF_FFFF_FFFF_FFFD);
        opImm(aluPassB, 5'd3, 5'd0, 64'hFFFF_FFFF_8000_0000, 64'hFFFF_FFFF_8000_0000);
        opImm(aluAdd, 5'd4, 5'd0, 64'h7FFF_FFFF, 64'h7FFF_FFFF);
        opReg(aluAdd, 5'd5, 5'd1, 5'd2, 64'd4);
        opReg(aluSub, 5'd6, 5'd1, 5'd2, 64'd10);
        opReg(aluSll, 5'd7, 5'd1, 5'd1, 64'h380);
        opReg(aluSrl, 5'd8, 5'd2, 5'd5, 64'h0FFF_FFFF_FFFF_FFFF);
        opReg(aluSra, 5'd9, 5'd2, 5'd5, 64'hFFFF_FFFF_FFFF_FFFF);
        opReg(aluSlt, 5'd10, 5'd2, 5'd1, 64'd1);
        opReg(aluSltu, 5'd11, 5'd2, 5'd1, 64'd0);
        opReg(aluXor, 5'd12, 5'd1, 5'd2, 64'hFFFF_FFFF_FFFF_FFFA);
        opReg(aluOr, 5'd13, 5'd1, 5'd2, 64'hFFFF_FFFF_FFFF_FFFF);
        opReg(aluAnd, 5'd14, 5'd1, 5'd2, 64'd5);
        opReg(aluAddw, 5'd15, 5'd4, 5'd1, 64'hFFFF_FFFF_8000_0006);
        opReg(aluSubw, 5'd16, 5'd3, 5'd1, 64'h0000_0000_7FFF_FFF9);
        opReg(aluSllw, 5'd17, 5'd4, 5'd1, 64'hFFFF_FFFF_FFFF_FF80);
        opReg(aluSrlw, 5'd18, 5'd3, 5'd5, 64'h0000_0000_0800_0000);
        opReg(aluSraw, 5'd19, 5'd3, 5'd5, 64'hFFFF_FFFF_F800_0000);
        opImm(aluAdd, 5'd0, 5'd0, 64'd99, 64'd99);
        readReg(5'd0, 64'd0);
        readReg(5'd6, 64'd10);
        readReg(5'd17, 64'hFFFF_FFFF_FFFF_FF80);
        // conditional branches
        branchRow(brBeq, aluSub, 5'd1, 5'd1, 64'h40, 1'b1, 64'd0);
        branchRow(brBeq, aluSub, 5'd1, 5'd2, 64'h40, 1'b0, 64'd10);
        branchRow(brBne, aluSub, 5'd1, 5'd2, 64'hFFFF_FFFF_FFFF_FFE0, 1'b1, 64'd10);
        branchRow(brBne, aluSub, 5'd1, 5'd1, 64'hFFFF_FFFF_FFFF_FFE0, 1'b0, 64'd0);
        branchRow(brBlt, aluSlt, 5'd2, 5'd1, 64'h80, 1'b1, 64'd1);
        branchRow(brBlt, aluSlt, 5'd1, 5'd2, 64'h80, 1'b0, 64'd0);
        branchRow(brBge, aluSlt, 5'd1, 5'd2, 64'h80, 1'b1, 64'd0);
        branchRow(brBge, aluSlt, 5'd2, 5'd1, 64'h80, 1'b0, 64'd1);
        // jal with an odd offset, jalr off x1
        c = baseCtrl();
        c.regWen = 1'b1;
        c.aluSrcA = 1'b0;
        c.srcB = constFour;
        c.branch = brJal;
        linkPc = curPc + 64'd4;
        addRow(c, 5'd21, 5'd0, 5'd0, 64'h101, curPc + 64'h100, curPc + 64'd4);
        c.branch = brJalr;
        addRow(c, 5'd22, 5'd1, 5'd0, 64'h10, 64'h16, curPc + 64'd4);
        readReg(5'd21, linkPc);
        // memory at 0x40
        opImm(aluAdd, 5'd23, 5'd0, memBase, memBase);
        opImm(aluPassB, 5'd24, 5'd0, 64'h8877_6655_4433_2211, 64'h8877_6655_4433_2211);
        memStore(memLd, 5'd24, 64'd0);
        memLoad(memLd, 5'd25, 64'd0, 64'h8877_6655_4433_2211);
        memLoad(memLb, 5'd25, 64'd7, 64'hFFFF_FFFF_FFFF_FF88);
        memLoad(memLbu, 5'd25, 64'd7, 64'h88);
        memLoad(memLh, 5'd25, 64'd6, 64'hFFFF_FFFF_FFFF_8877);
        memLoad(memLhu, 5'd25, 64'd2, 64'h4433);
        memLoad(memLw, 5'd25, 64'd4, 64'hFFFF_FFFF_8877_6655);
        memLoad(memLwu, 5'd25, 64'd4, 64'h8877_6655);
        memLoad(memLw, 5'd25, 64'd0, 64'h4433_2211);
        memLoad(memLw, 5'd25, 64'd8, 64'd0);
        memStore(memLw, 5'd1, 64'd4);
        memStore(memLh, 5'd2, 64'd2);
        memStore(memLb, 5'd13, 64'd1);
        memLoad(memLd, 5'd25, 64'd0, 64'h0000_0007_FFFD_FF11);
        memLoad(memLh, 5'd25, 64'd2, 64'hFFFF_FFFF_FFFF_FFFD);
        memLoad(memLbu, 5'd25, 64'd1, 64'hFF);
        readReg(5'd25, 64'hFF);
        // mtvec write, set, clear
        csrRow(csrWrite, 5'd26, 5'd24, csrMtvec, 64'd0);
        csrRow(csrSet, 5'd27, 5'd1, csrMtvec, 64'h8877_6655_4433_2211);
        csrRow(csrClear, 5'd28, 5'd14, csrMtvec, 64'h8877_6655_4433_2217);
        csrRow(csrSet, 5'd0, 5'd0, csrMtvec, 64'h8877_6655_4433_2212);
        readReg(5'd27, 64'h8877_6655_4433_2211);
        csrRow(csrWrite, 5'd0, 5'd1, 12'h7C0, 64'd0);
        csrRow(csrSet, 5'd0, 5'd0, 12'h7C0, 64'd0);
        // epc then mret
        c = baseCtrl();
        c.csrWen = 1'b1;
        c.csrOp = csrWrite;
        c.csrToReg = 1'b1;
        c.epc = 1'b1;
        epcPc = curPc;
        addRow(c, 5'd0, 5'd0, 5'd0, {52'd0, csrMepc}, curPc + 64'd4, 64'd0);
        c = baseCtrl();
        c.mret = 1'b1;
        addRow(c, 5'd0, 5'd0, 5'd0, 64'd0, epcPc, 64'd0);
        csrRow(csrWrite, 5'd0, 5'd1, csrMepc, epcPc);
        addRow(c, 5'd0, 5'd0, 5'd0, 64'd0, 64'd6, 64'd0);
    endtask

    initial begin
        rowT r;
        reset = 1'b1;
        // a write into x5 is attempted for the whole reset
        ctrl = '0;
        ctrl.regWen = 1'b1;
        ctrl.srcB = fromImm;
        rd = 5'd5;
        rs1 = 5'd5;
        rs2 = '0;
        pc = '0;
        imm = 64'h5A;
        checkEn = 1'b0;
        expDnpc = '0;
        expWb = '0;
        rowIdx = 0;
        buildTable();
        tableReady = 1'b1;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            r = rows[i];
            ctrl = r.ctrl;
            rd = r.rd;
            rs1 = r.rs1;
            rs2 = r.rs2;
            pc = r.pc;
            imm = r.imm;
            expDnpc = r.expDnpc;
            expWb = r.expWb;
            rowIdx = i;
            checkEn = 1'b1;
        end
        @(negedge clk);
        checkEn = 1'b0;
        ctrl = '0;
        #1;
        $display("rows %0d, checks %0d, errors %0d, assertion failures %0d",
                 rows.size(), checkCount, errorCount, DUT.uChecker.failCount);
        if (checkCount != rows.size()) begin
            $display("not every row of the table was checked");
        end
        if (errorCount == 0 && DUT.uChecker.failCount == 0 && checkCount == rows.size()) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (tableReady);
        #((rows.size() + resetCycles + 10) * 2 * halfPeriod);
        $display("run timed out before all rows were applied");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: verilog.f
src/exuPkg.sv
src/regFile.sv
src/alu.sv
src/csrUnit.sv
src/nextPc.sv
src/dataMem.sv
src/execUnit.sv
tests/execUnit_checker.sv
tests/execMonitor.sv
tests/execUnit_tb.sv

// File: run.sh
#!/bin/sh
# build the execute-stage testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f verilog.f --top-module execUnit_tb -o execSim \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/execSim +verilator+error+limit+100) ; echo "$out"
echo "$out" | grep -qx "ALL CHECKS PASSED" && exit 0 || exit 1
